/* bench/tb_peri_subsys.sv */
// Peripheral subsystem testbench
`timescale 1ns/1ns

module tb_peri_subsys;
    // Ten UART frames of 80 cycles plus bus traffic and PWM windows fit well inside.
    localparam int cycle_limit = 20000;
    localparam int bit_cycles  = 8;
    localparam int pwm_period_val = 9;
    localparam int pwm_duty_val   = 3;
    localparam peri_pkg::peri_addr_t unmapped_addr = 12'h7F0;
    localparam peri_pkg::peri_addr_t pwm2_base =
        peri_pkg::peri_addr_t'(peri_pkg::pwm_base + 2 * peri_pkg::pwm_stride);

    logic                 clk, rst_n, re, we, loop_closed;
    peri_pkg::peri_addr_t addr;
    peri_pkg::peri_data_t wdata, rdata;
    logic [31:0]          gpio_in, randomness, gpio_out, gpio_oe;
    logic                 ready, txd;
    logic [1:0]           irq;
    wire                  rxd;
    logic [31:0]          seed = 32'h705;
    int                   errors = 0;
    int                   checks = 0;
    logic                 ready_seen = 1'b0;

    // Loopback from txd to rxd, opened for the framing test.
    assign rxd = loop_closed ? txd : 1'b1;

    peri_subsys peri_subsys_inst (
        .clk (clk), .rst_n (rst_n), .re (re), .we (we), .addr (addr),
        .wdata (wdata), .rxd (rxd), .gpio_in (gpio_in), .randomness (randomness),
        .rdata (rdata), .ready (ready), .txd (txd), .gpio_out (gpio_out),
        .gpio_oe (gpio_oe), .irq (irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("Error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // Ready must follow the strobe by exactly one cycle.
    task automatic wait_ready();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ready && waited < 4);
        assert (ready)
        else begin
            errors++;
            $display("No ready seen within %0d cycles of a bus strobe at address %h",
                     waited, addr);
        end
        if (ready) check_value("ready latency", 1, waited);
    endtask

    task automatic bus_write(input peri_pkg::peri_addr_t a, input peri_pkg::peri_data_t d);
        @(negedge clk);
        we    = 1'b1;
        addr  = a;
        wdata = d;
        wait_ready();
        we = 1'b0;
    endtask

    task automatic bus_read(input peri_pkg::peri_addr_t a, output peri_pkg::peri_data_t d);
        @(negedge clk);
        re   = 1'b1;
        addr = a;
        wait_ready();
        d  = rdata;
        re = 1'b0;
    endtask

    // Poll tx_full before each push.
    task automatic send_byte(input peri_pkg::uart_byte_t b);
        peri_pkg::peri_data_t status;
        int polls;
        polls = 0;
        do begin
            bus_read(peri_pkg::uart_base + peri_pkg::reg_status, status);
            polls++;
        end while (status[1] && polls < 200);
        assert (!status[1])
        else begin
            errors++;
            $display("Transmit FIFO stayed full while sending a byte");
        end
        bus_write(peri_pkg::uart_base + peri_pkg::reg_data, {24'h0, b});
    endtask

    task automatic wait_tx_idle(input int limit);
        int waited;
        waited = 0;
        while (!irq[0] && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (irq[0])
        else begin
            errors++;
            $display("Transmitter did not become empty within %0d cycles", limit);
        end
    endtask

    // Decodes one frame on txd at bit centres.
    task automatic capture_frame(output peri_pkg::uart_byte_t value);
        int waited;
        waited = 0;
        value  = '0;
        while (txd && waited < 64) begin
            @(negedge clk);
            waited++;
        end
        assert (!txd)
        else begin
            errors++;
            $display("No start bit appeared on txd");
        end
        repeat (bit_cycles / 2) @(negedge clk);
        check_value("txd start bit", 0, txd);
        check_value("irq[0] during frame", 0, irq[0]);
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cycles) @(negedge clk);
            value[i] = txd;
        end
        repeat (bit_cycles) @(negedge clk);
        check_value("txd stop bit", 1, txd);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(ready && ready_seen))
            else begin
                errors++;
                $display("ready stayed high for more than one cycle");
            end
        end
        ready_seen = ready;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        peri_pkg::peri_data_t value, rd_val, out_val, oe_val;
        peri_pkg::uart_byte_t sent [3];
        peri_pkg::uart_byte_t got;
        int tries;
        int high_cnt;
        rst_n       = 1'b0;
        re          = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        gpio_in     = '0;
        randomness  = '0;
        loop_closed = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Reset state and unmapped read.
        check_value("txd", 1, txd);
        check_value("irq", 2'b01, irq);
        check_value("gpio_out", 0, gpio_out);
        check_value("gpio_oe", 0, gpio_oe);
        check_value("ready", 0, ready);
        bus_read(unmapped_addr, rd_val);
        check_value("rdata unmapped", 0, rd_val);

        // GPIO outputs and synchronized inputs.
        out_val = lcg_next();
        oe_val  = lcg_next();
        bus_write(peri_pkg::gpio_base + peri_pkg::gpio_out, out_val);
        bus_write(peri_pkg::gpio_base + peri_pkg::gpio_oe, oe_val);
        check_value("gpio_out", out_val, gpio_out);
        check_value("gpio_oe", oe_val, gpio_oe);
        value   = lcg_next();
        gpio_in = value;
        tries   = 0;
        do begin
            bus_read(peri_pkg::gpio_base + peri_pkg::gpio_in, rd_val);
            tries++;
        end while (rd_val !== value && tries < 4);
        check_value("gpio_in", value, rd_val);

        // Randomness register.
        repeat (3) begin
            randomness = lcg_next();
            bus_read(peri_pkg::rng_base, rd_val);
            check_value("randomness", randomness, rd_val);
        end

        // Transmit framing with the loopback open.
        loop_closed = 1'b0;
        bus_write(peri_pkg::uart_base + peri_pkg::reg_div, bit_cycles);
        check_value("irq[0] before frame", 1, irq[0]);
        value   = lcg_next();
        sent[0] = value[7:0];
        bus_write(peri_pkg::uart_base + peri_pkg::reg_data, {24'h0, sent[0]});
        capture_frame(got);
        check_value("txd frame", sent[0], got);
        wait_tx_idle(bit_cycles);

        // Loopback of three bytes.
        loop_closed = 1'b1;
        check_value("irq[1] before loopback", 0, irq[1]);
        for (int i = 0; i < 3; i++) begin
            value   = lcg_next();
            sent[i] = value[7:0];
            send_byte(sent[i]);
        end
        wait_tx_idle(4 * 10 * bit_cycles);
        repeat (2 * bit_cycles) @(negedge clk);
        bus_read(peri_pkg::uart_base + peri_pkg::reg_status, rd_val);
        check_value("status rx_valid", 1, rd_val[2]);
        check_value("irq[1]", 1, irq[1]);
        for (int i = 0; i < 3; i++) begin
            bus_read(peri_pkg::uart_base + peri_pkg::reg_data, rd_val);
            check_value("uart rx data", sent[i], rd_val);
        end
        bus_read(peri_pkg::uart_base + peri_pkg::reg_status, rd_val);
        check_value("status rx_valid", 0, rd_val[2]);
        check_value("irq[1]", 0, irq[1]);

        // Six bytes into a four entry receive FIFO.
        repeat (6) begin
            value = lcg_next();
            send_byte(value[7:0]);
        end
        wait_tx_idle(8 * 10 * bit_cycles);
        repeat (2 * bit_cycles) @(negedge clk);
        bus_read(peri_pkg::uart_base + peri_pkg::reg_status, rd_val);
        check_value("status rx_overrun", 1, rd_val[3]);
        bus_read(peri_pkg::uart_base + peri_pkg::reg_status, rd_val);
        check_value("status rx_overrun after read", 0, rd_val[3]);

        // PWM channel 2 takes over pin 2.
        bus_write(pwm2_base + peri_pkg::pwm_period, pwm_period_val);
        bus_write(pwm2_base + peri_pkg::pwm_duty, pwm_duty_val);
        bus_read(pwm2_base + peri_pkg::pwm_period, rd_val);
        check_value("pwm period", pwm_period_val, rd_val);
        // Pin 2 left undriven by the register before the takeover.
        oe_val[2] = 1'b0;
        bus_write(peri_pkg::gpio_base + peri_pkg::gpio_oe, oe_val);
        bus_write(peri_pkg::gpio_base + peri_pkg::gpio_ext, 32'h4);
        high_cnt = 0;
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            high_cnt += gpio_out[2];
            check_value("gpio_oe[2]", 1, gpio_oe[2]);
            if (i % (pwm_period_val + 1) == pwm_period_val) begin
                check_value("pwm high cycles", pwm_duty_val, high_cnt);
                high_cnt = 0;
            end
        end
        bus_write(peri_pkg::gpio_base + peri_pkg::gpio_ext, 32'h0);
        check_value("gpio_out", out_val, gpio_out);
        check_value("gpio_oe", oe_val, gpio_oe);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* common/peri_pkg.sv */
// Peripheral block definitions
package peri_pkg;

    // Bus and payload widths.
    typedef logic [11:0] peri_addr_t;
    typedef logic [31:0] peri_data_t;
    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] uart_div_t;
    typedef logic [15:0] pwm_cnt_t;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} uart_tx_state_t;
    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} uart_rx_state_t;

    localparam int num_pwm       = 4;
    localparam int uart_depth    = 4;
    localparam int uart_ptr_w    = $clog2(uart_depth);
    localparam int uart_init_div = 8;

    // Block base addresses.
    localparam peri_addr_t uart_base  = 12'h000;
    localparam peri_addr_t gpio_base  = 12'h200;
    localparam peri_addr_t rng_base   = 12'h300;
    localparam peri_addr_t pwm_base   = 12'h480;
    localparam peri_addr_t pwm_stride = 12'h010;

    // Register offsets inside a block.
    localparam logic [3:0] reg_data   = 4'h0;
    localparam logic [3:0] reg_status = 4'h4;
    localparam logic [3:0] reg_div    = 4'h8;
    localparam logic [3:0] gpio_out   = 4'h0;
    localparam logic [3:0] gpio_oe    = 4'h4;
    localparam logic [3:0] gpio_in    = 4'h8;
    localparam logic [3:0] gpio_ext   = 4'hC;
    localparam logic [3:0] pwm_period = 4'h0;
    localparam logic [3:0] pwm_duty   = 4'h4;

endpackage

/* compile.f */
common/peri_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/peri_uart.sv
src/peri_pwm.sv
src/peri_gpio.sv
src/peri_decode.sv
src/peri_subsys.sv
bench/tb_peri_subsys.sv

/* src/peri_decode.sv */
// Peripheral address decoder
`timescale 1ns/1ns

module peri_decode (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         re,
    input  logic                         we,
    input  peri_pkg::peri_addr_t         addr,
    input  peri_pkg::peri_data_t         rdata_uart,
    input  peri_pkg::peri_data_t         rdata_gpio,
    input  peri_pkg::peri_data_t         rdata_rng,
    input  peri_pkg::peri_data_t         rdata_pwm [peri_pkg::num_pwm],
    output logic                         ready,
    output peri_pkg::peri_data_t         rdata,
    output logic                         access,
    output logic                         sel_uart,
    output logic                         sel_gpio,
    output logic                         sel_rng,
    output logic [peri_pkg::num_pwm-1:0] sel_pwm,
    output logic [3:0]                   offset
);
    peri_pkg::peri_addr_t         blk;
    logic                         strobe_q;
    logic                         rsel_uart, rsel_gpio, rsel_rng;
    logic [peri_pkg::num_pwm-1:0] rsel_pwm;

    // Every block spans 16 bytes.
    assign blk    = {addr[11:4], 4'h0};
    assign offset = {addr[3:2], 2'b00};

    // First cycle of a held strobe.
    assign access = (re | we) & ~strobe_q;

    assign sel_uart = blk == peri_pkg::uart_base;
    assign sel_gpio = blk == peri_pkg::gpio_base;
    assign sel_rng  = blk == peri_pkg::rng_base;

    always_comb begin
        for (int i = 0; i < peri_pkg::num_pwm; i++) begin
            sel_pwm[i] = blk == peri_pkg::peri_addr_t'(peri_pkg::pwm_base
                                                       + i * peri_pkg::pwm_stride);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            strobe_q  <= 1'b0;
            ready     <= 1'b0;
            rsel_uart <= 1'b0;
            rsel_gpio <= 1'b0;
            rsel_rng  <= 1'b0;
            rsel_pwm  <= '0;
        end else begin
            strobe_q <= re | we;
            ready    <= access;
            if (access) begin
                rsel_uart <= re & sel_uart;
                rsel_gpio <= re & sel_gpio;
                rsel_rng  <= re & sel_rng;
                rsel_pwm  <= re ? sel_pwm : '0;
            end
        end
    end

    // Return data from whichever block answered, else zero.
    always_comb begin
        rdata = '0;
        if (rsel_uart) rdata |= rdata_uart;
        if (rsel_gpio) rdata |= rdata_gpio;
        if (rsel_rng) rdata |= rdata_rng;
        for (int i = 0; i < peri_pkg::num_pwm; i++) begin
            if (rsel_pwm[i]) rdata |= rdata_pwm[i];
        end
    end

endmodule

/* src/peri_gpio.sv */
// GPIO port with PWM takeover
`timescale 1ns/1ns

module peri_gpio (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         sel,
    input  logic                         access,
    input  logic                         re,
    input  logic                         we,
    input  logic [3:0]                   offset,
    input  peri_pkg::peri_data_t         wdata,
    input  logic [peri_pkg::num_pwm-1:0] pwm_sig,
    input  logic [31:0]                  gpio_in,
    output peri_pkg::peri_data_t         rdata,
    output logic [31:0]                  gpio_out,
    output logic [31:0]                  gpio_oe
);
    logic [31:0]                  out_q, oe_q;
    logic [peri_pkg::num_pwm-1:0] ext_q;
    logic [31:0]                  in_meta, in_sync;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q <= '0;
            oe_q  <= '0;
            ext_q <= '0;
        end else if (sel && access && we) begin
            case (offset)
                peri_pkg::gpio_out: out_q <= wdata;
                peri_pkg::gpio_oe:  oe_q  <= wdata;
                peri_pkg::gpio_ext: ext_q <= wdata[peri_pkg::num_pwm-1:0];
                default:            ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
        if (sel && access && re) begin
            case (offset)
                peri_pkg::gpio_out: rdata <= out_q;
                peri_pkg::gpio_oe:  rdata <= oe_q;
                peri_pkg::gpio_in:  rdata <= in_sync;
                default:            rdata <= {{(32 - peri_pkg::num_pwm){1'b0}}, ext_q};
            endcase
        end
    end

    // Low pins handed to a PWM channel are always driven.
    always_comb begin
        gpio_out = out_q;
        gpio_oe  = oe_q;
        for (int i = 0; i < peri_pkg::num_pwm; i++) begin
            if (ext_q[i]) begin
                gpio_out[i] = pwm_sig[i];
                gpio_oe[i]  = 1'b1;
            end
        end
    end

endmodule

/* src/peri_pwm.sv */
// PWM generator
`timescale 1ns/1ns

module peri_pwm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sel,
    input  logic                 access,
    input  logic                 re,
    input  logic                 we,
    input  logic [3:0]           offset,
    input  peri_pkg::peri_data_t wdata,
    output peri_pkg::peri_data_t rdata,
    output logic                 pwm_out
);
    peri_pkg::pwm_cnt_t period, duty, cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            period  <= '0;
            duty    <= '0;
            cnt     <= '0;
            pwm_out <= 1'b0;
        end else begin
            // Counter wraps after reaching period.
            cnt     <= (cnt >= period) ? '0 : cnt + 16'd1;
            pwm_out <= cnt < duty;
            if (sel && access && we) begin
                cnt <= '0;
                if (offset == peri_pkg::pwm_period) period <= wdata[15:0];
                if (offset == peri_pkg::pwm_duty) duty <= wdata[15:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel && access && re) begin
            case (offset)
                peri_pkg::pwm_period: rdata <= {16'h0, period};
                peri_pkg::pwm_duty:   rdata <= {16'h0, duty};
                default:              rdata <= '0;
            endcase
        end
    end

endmodule

/* src/peri_subsys.sv */
// Peripheral subsystem
`timescale 1ns/1ns

module peri_subsys (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 re,
    input  logic                 we,
    input  peri_pkg::peri_addr_t addr,
    input  peri_pkg::peri_data_t wdata,
    input  logic                 rxd,
    input  logic [31:0]          gpio_in,
    input  logic [31:0]          randomness,
    output peri_pkg::peri_data_t rdata,
    output logic                 ready,
    output logic                 txd,
    output logic [31:0]          gpio_out,
    output logic [31:0]          gpio_oe,
    output logic [1:0]           irq
);
    logic                         access;
    logic                         sel_uart, sel_gpio, sel_rng;
    logic [peri_pkg::num_pwm-1:0] sel_pwm;
    logic [3:0]                   offset;
    peri_pkg::peri_data_t         rdata_uart, rdata_gpio, rdata_rng;
    peri_pkg::peri_data_t         rdata_pwm [peri_pkg::num_pwm];
    logic [peri_pkg::num_pwm-1:0] pwm_sig;
    logic                         tx_empty, rx_valid;

    assign irq = {rx_valid, tx_empty};

    peri_decode decode_inst (
        .clk (clk), .rst_n (rst_n), .re (re), .we (we), .addr (addr),
        .rdata_uart (rdata_uart), .rdata_gpio (rdata_gpio),
        .rdata_rng (rdata_rng), .rdata_pwm (rdata_pwm),
        .ready (ready), .rdata (rdata), .access (access),
        .sel_uart (sel_uart), .sel_gpio (sel_gpio), .sel_rng (sel_rng),
        .sel_pwm (sel_pwm), .offset (offset)
    );

    peri_uart uart_inst (
        .clk (clk), .rst_n (rst_n), .sel (sel_uart), .access (access),
        .re (re), .we (we), .offset (offset), .wdata (wdata), .rxd (rxd),
        .rdata (rdata_uart), .txd (txd), .tx_empty (tx_empty), .rx_valid (rx_valid)
    );

    peri_gpio gpio_inst (
        .clk (clk), .rst_n (rst_n), .sel (sel_gpio), .access (access),
        .re (re), .we (we), .offset (offset), .wdata (wdata),
        .pwm_sig (pwm_sig), .gpio_in (gpio_in),
        .rdata (rdata_gpio), .gpio_out (gpio_out), .gpio_oe (gpio_oe)
    );

    for (genvar i = 0; i < peri_pkg::num_pwm; i++) begin : gen_pwm
        peri_pwm pwm_inst (
            .clk (clk), .rst_n (rst_n), .sel (sel_pwm[i]), .access (access),
            .re (re), .we (we), .offset (offset), .wdata (wdata),
            .rdata (rdata_pwm[i]), .pwm_out (pwm_sig[i])
        );
    end

    // Randomness sampled on read.
    always_ff @(posedge clk) begin
        if (sel_rng && access && re) rdata_rng <= randomness;
    end

endmodule

/* uart/peri_uart.sv */
// UART register block
`timescale 1ns/1ns

module peri_uart (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sel,
    input  logic                 access,
    input  logic                 re,
    input  logic                 we,
    input  logic [3:0]           offset,
    input  peri_pkg::peri_data_t wdata,
    input  logic                 rxd,
    output peri_pkg::peri_data_t rdata,
    output logic                 txd,
    output logic                 tx_empty,
    output logic                 rx_valid
);
    peri_pkg::uart_div_t             div;
    peri_pkg::uart_byte_t            tx_mem [peri_pkg::uart_depth];
    peri_pkg::uart_byte_t            rx_mem [peri_pkg::uart_depth];
    logic [peri_pkg::uart_ptr_w-1:0] tx_wp, tx_rp, rx_wp, rx_rp;
    logic [peri_pkg::uart_ptr_w:0]   tx_cnt, rx_cnt;
    logic                            rx_overrun;
    logic                            wr, rd;
    logic                            tx_busy, tx_start, tx_full, tx_push;
    logic                            rx_full, rx_push, rx_pop;
    logic                            rx_byte_valid;
    peri_pkg::uart_byte_t            rx_byte;

    assign wr = sel & access & we;
    assign rd = sel & access & re;

    assign tx_full  = tx_cnt == peri_pkg::uart_depth;
    assign tx_empty = tx_cnt == '0 && !tx_busy;
    assign tx_push  = wr && offset == peri_pkg::reg_data && !tx_full;
    // Hand the oldest byte over once the serializer is free.
    assign tx_start = !tx_busy && tx_cnt != '0;

    assign rx_full  = rx_cnt == peri_pkg::uart_depth;
    assign rx_valid = rx_cnt != '0;
    assign rx_push  = rx_byte_valid && !rx_full;
    assign rx_pop   = rd && offset == peri_pkg::reg_data && rx_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div        <= peri_pkg::uart_div_t'(peri_pkg::uart_init_div);
            tx_wp      <= '0;
            tx_rp      <= '0;
            tx_cnt     <= '0;
            rx_wp      <= '0;
            rx_rp      <= '0;
            rx_cnt     <= '0;
            rx_overrun <= 1'b0;
        end else begin
            if (wr && offset == peri_pkg::reg_div) div <= wdata[15:0];
            if (tx_push) tx_wp <= tx_wp + 1'b1;
            if (tx_start) tx_rp <= tx_rp + 1'b1;
            tx_cnt <= tx_cnt + tx_push - tx_start;
            if (rx_push) rx_wp <= rx_wp + 1'b1;
            if (rx_pop) rx_rp <= rx_rp + 1'b1;
            rx_cnt <= rx_cnt + rx_push - rx_pop;
            // A new overrun wins over a status read in the same cycle.
            if (rd && offset == peri_pkg::reg_status) rx_overrun <= 1'b0;
            if (rx_byte_valid && rx_full) rx_overrun <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_push) tx_mem[tx_wp] <= wdata[7:0];
        if (rx_push) rx_mem[rx_wp] <= rx_byte;
        if (rd) begin
            case (offset)
                peri_pkg::reg_data:   rdata <= {24'h0, rx_valid ? rx_mem[rx_rp] : 8'h00};
                peri_pkg::reg_status: rdata <= {28'h0, rx_overrun, rx_valid, tx_full, tx_empty};
                peri_pkg::reg_div:    rdata <= {16'h0, div};
                default:              rdata <= '0;
            endcase
        end
    end

    uart_tx tx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .div     (div),
        .start   (tx_start),
        .byte_in (tx_mem[tx_rp]),
        .busy    (tx_busy),
        .txd     (txd)
    );

    uart_rx rx_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .div        (div),
        .rxd        (rxd),
        .byte_valid (rx_byte_valid),
        .byte_out   (rx_byte)
    );

endmodule

/* uart/uart_rx.sv */
// UART 8N1 receiver
`timescale 1ns/1ns

module uart_rx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  peri_pkg::uart_div_t  div,
    input  logic                 rxd,
    output logic                 byte_valid,
    output peri_pkg::uart_byte_t byte_out
);
    peri_pkg::uart_rx_state_t state;
    peri_pkg::uart_div_t      bit_cnt;
    logic [2:0]               bit_idx;
    logic                     rxd_meta, rxd_sync, rxd_last;
    logic                     half_done, bit_done;

    assign half_done = bit_cnt == {1'b0, div[15:1]} - 16'd1;
    assign bit_done  = bit_cnt == div - 16'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta   <= 1'b1;
            rxd_sync   <= 1'b1;
            rxd_last   <= 1'b1;
            state      <= peri_pkg::rx_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            rxd_meta   <= rxd;
            rxd_sync   <= rxd_meta;
            rxd_last   <= rxd_sync;
            byte_valid <= 1'b0;
            bit_cnt    <= bit_cnt + 16'd1;
            case (state)
                peri_pkg::rx_idle: begin
                    bit_cnt <= '0;
                    // Falling edge starts a frame.
                    if (rxd_last && !rxd_sync) state <= peri_pkg::rx_start;
                end
                peri_pkg::rx_start: begin
                    if (half_done) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        // Glitch check at the start bit centre.
                        state   <= rxd_sync ? peri_pkg::rx_idle : peri_pkg::rx_data;
                    end
                end
                peri_pkg::rx_data: begin
                    if (bit_done) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= peri_pkg::rx_stop;
                    end
                end
                default: begin
                    if (bit_done) begin
                        byte_valid <= rxd_sync;
                        state      <= peri_pkg::rx_idle;
                    end
                end
            endcase
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (state == peri_pkg::rx_data && bit_done) byte_out[bit_idx] <= rxd_sync;
    end

endmodule

/* uart/uart_tx.sv */
// UART 8N1 transmitter
`timescale 1ns/1ns

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  peri_pkg::uart_div_t  div,
    input  logic                 start,
    input  peri_pkg::uart_byte_t byte_in,
    output logic                 busy,
    output logic                 txd
);
    peri_pkg::uart_tx_state_t state;
    peri_pkg::uart_div_t      bit_cnt;
    logic [2:0]               bit_idx;
    peri_pkg::uart_byte_t     tx_byte;
    logic                     bit_done;

    assign busy     = state != peri_pkg::tx_idle;
    assign bit_done = bit_cnt == div - 16'd1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= peri_pkg::tx_idle;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            bit_cnt <= (bit_done || !busy) ? '0 : bit_cnt + 16'd1;
            case (state)
                peri_pkg::tx_idle: begin
                    if (start) begin
                        state <= peri_pkg::tx_start;
                        txd   <= 1'b0;
                    end
                end
                peri_pkg::tx_start: begin
                    if (bit_done) begin
                        state   <= peri_pkg::tx_data;
                        bit_idx <= '0;
                        txd     <= tx_byte[0];
                    end
                end
                peri_pkg::tx_data: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state <= peri_pkg::tx_stop;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= tx_byte[bit_idx + 3'd1];
                        end
                    end
                end
                default: begin
                    if (bit_done) state <= peri_pkg::tx_idle;
                end
            endcase
        end
    end

    // Character latched when the frame begins.
    always_ff @(posedge clk) begin
        if (start && !busy) tx_byte <= byte_in;
    end

endmodule
